// File: sources.f
hdl/aluPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/execCore.sv
verification/clockGen.sv
verification/execCoreTb.sv

// File: Makefile
TOP     := execCoreTb
SIM_LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(SIM_LOG)
	grep -qx "all tests passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: verification/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;

   localparam int loadIters  = 8;
   localparam int arithIters = 6;
   localparam int mdIters    = 4;
   localparam int logicIters = 8;
   localparam int chainLen   = 12;                  // Per dependency distance
   localparam int illIters   = 4;
   localparam int totalInstrs = (2*loadIters + 3) + (16 + 7*arithIters)
                              + (2 + 9*mdIters + 64) + 10*logicIters
                              + 3*(2 + chainLen) + (2 + 3*illIters);
   localparam int watchdogCycles = totalInstrs + 50;

   typedef struct packed {
      logic            illegal;                     // Word must be dropped
      aluPkg::aluRes_t res;
   } expRes_t;

   logic                         clk;
   logic                         rstN;
   logic                         instrValid;
   logic [31:0]                  instr;
   aluPkg::aluRes_t              wb;
   logic                         illegal;
   logic [aluPkg::dataWidth-1:0] regModel [0:aluPkg::numRegs-1];   // Architectural state
   expRes_t                      expIn;             // Set with the issued word
   expRes_t                      expMid;
   expRes_t                      expOut;            // Lines up with wb
   int                           seed = 66847;
   int                           errCount;
   int                           testErrStart;
   int                           testInstrs;
   int                           testsRun;
   int                           testsFailed;
   string                        testName = "reset";

   clockGen clockGen0 (.clk(clk), .rstN(rstN));

   execCore dut0 (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .instr      (instr),
      .wb         (wb),
      .illegal    (illegal)
   );

   // Expected results ride two stages behind the issued word
   always @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         expMid <= '0;
         expOut <= '0;
      end else begin
         expMid <= expIn;
         expOut <= expMid;
      end
   end

   task automatic logMismatch(input string what, input logic [63:0] expV,
                              input logic [63:0] actV);
      $display("ERROR %s %s expected %0h actual %0h", testName, what, expV, actV);
      errCount++;
   endtask

   chkValid: assert property (@(posedge clk) disable iff (!rstN)
      wb.valid == expOut.res.valid)
      else logMismatch("wb.valid", 64'($sampled(expOut.res.valid)), 64'($sampled(wb.valid)));

   chkIllegal: assert property (@(posedge clk) disable iff (!rstN)
      illegal == expOut.illegal)
      else logMismatch("illegal", 64'($sampled(expOut.illegal)), 64'($sampled(illegal)));

   chkValue: assert property (@(posedge clk) disable iff (!rstN)
      !expOut.res.valid || (wb.value == expOut.res.value))
      else logMismatch("value", 64'($sampled(expOut.res.value)), 64'($sampled(wb.value)));

   chkFlags: assert property (@(posedge clk) disable iff (!rstN)
      !expOut.res.valid || ({wb.zero, wb.overflow, wb.carryOut} ==
      {expOut.res.zero, expOut.res.overflow, expOut.res.carryOut}))
      else logMismatch("zero/ovf/carry",
         64'({$sampled(expOut.res.zero), $sampled(expOut.res.overflow),
              $sampled(expOut.res.carryOut)}),
         64'({$sampled(wb.zero), $sampled(wb.overflow), $sampled(wb.carryOut)}));

   chkDest: assert property (@(posedge clk) disable iff (!rstN)
      !expOut.res.valid || ({wb.dest, wb.writes} == {expOut.res.dest, expOut.res.writes}))
      else logMismatch("dest/writes", 64'({$sampled(expOut.res.dest),
         $sampled(expOut.res.writes)}), 64'({$sampled(wb.dest), $sampled(wb.writes)}));

   function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] sh);
      return {aluPkg::opcRType, rs, rt, rd, sh, funct};
   endfunction

   function automatic logic [31:0] encI(input logic [5:0] opc, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
      return {opc, rs, rt, imm};
   endfunction

   // ISA-level result of one word against the model registers
   function automatic expRes_t model(input logic [31:0] w);
      expRes_t     e;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] v;
      logic [32:0] wide;
      logic [63:0] prod;
      longint      exact;                           // Signed result before wrap
      logic        ok;
      logic        isAdd;
      logic        isSub;
      logic        ovf;
      logic        cy;
      logic [4:0]  dest;
      e     = '0;
      a     = regModel[w[25:21]];
      b     = regModel[w[20:16]];
      v     = '0;
      ok    = 1'b1;
      isAdd = 1'b0;
      isSub = 1'b0;
      ovf   = 1'b0;
      cy    = 1'b0;
      dest  = w[15:11];                             // rd unless I-type
      case (w[31:26])
         aluPkg::opcRType: begin
            case (w[5:0])
               aluPkg::functAdd:  isAdd = 1'b1;
               aluPkg::functSub:  isSub = 1'b1;
               aluPkg::functMul: begin
                  prod = {32'b0, a} * {32'b0, b};
                  v    = prod[31:0];
                  ovf  = (prod[63:32] != '0);       // High word lost
               end
               aluPkg::functDivu: begin
                  v   = (b == '0) ? 32'hFFFF_FFFF : a / b;
                  ovf = (b == '0);
               end
               aluPkg::functSll:  v = b << w[10:6];
               aluPkg::functSrl:  v = b >> w[10:6];
               aluPkg::functAnd:  v = a & b;
               aluPkg::functOr:   v = a | b;
               aluPkg::functXor:  v = a ^ b;
               aluPkg::functNor:  v = ~(a | b);
               aluPkg::functSlt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default:           ok = 1'b0;
            endcase
         end
         aluPkg::opcAddi: begin
            b     = {{16{w[15]}}, w[15:0]};
            dest  = w[20:16];
            isAdd = 1'b1;
         end
         aluPkg::opcOri: begin
            v    = a | {16'h0000, w[15:0]};
            dest = w[20:16];
         end
         aluPkg::opcLui: begin
            v    = {w[15:0], 16'h0000};
            dest = w[20:16];
         end
         default: ok = 1'b0;
      endcase
      if (isAdd) begin
         wide  = {1'b0, a} + {1'b0, b};
         exact = longint'($signed(a)) + longint'($signed(b));
         v     = wide[31:0];
         cy    = wide[32];
         ovf   = (exact != longint'($signed(v)));   // Does not fit in 32 bits
      end
      if (isSub) begin
         exact = longint'($signed(a)) - longint'($signed(b));
         v     = a - b;
         cy    = (a >= b);                          // No borrow
         ovf   = (exact != longint'($signed(v)));
      end
      e.illegal        = !ok;
      e.res.valid      = ok;
      e.res.dest       = dest;
      e.res.writes     = (dest != '0);
      e.res.value      = v;
      e.res.zero       = (v == '0);
      e.res.overflow   = ovf;
      e.res.carryOut   = cy;
      return e;
   endfunction

   // Unknown opcode or funct word with rt and rd on r5
   function automatic logic [31:0] illegalWord(input int pick, input logic [31:0] rnd);
      logic [31:0] w;
      w        = rnd;
      w[20:16] = 5'd5;
      w[15:11] = 5'd5;
      case (pick % 8)
         0: w[31:26] = 6'h02;                       // j
         1: w[31:26] = 6'h04;                       // beq
         2: w[31:26] = 6'h23;                       // lw
         3: w[31:26] = 6'h2B;                       // sw
         4: w = {aluPkg::opcRType, w[25:6], 6'h21}; // addu
         5: w = {aluPkg::opcRType, w[25:6], 6'h08}; // jr
         6: w = {aluPkg::opcRType, w[25:6], 6'h03}; // sra
         default: w = {aluPkg::opcRType, w[25:6], 6'h18};   // mult
      endcase
      return w;
   endfunction

   task automatic issue(input logic [31:0] w);
      expRes_t e;
      e = model(w);
      if (e.res.valid && e.res.writes) begin
         regModel[e.res.dest] = e.res.value;
      end
      instrValid <= 1'b1;
      instr      <= w;
      expIn      <= e;
      testInstrs++;
      @(posedge clk);
   endtask

   task automatic idle();
      instrValid <= 1'b0;
      expIn      <= '0;
      @(posedge clk);
   endtask

   task automatic loadConst(input logic [4:0] r, input logic [31:0] v);
      issue(encI(aluPkg::opcLui, r, 5'd0, v[31:16]));
      issue(encI(aluPkg::opcOri, r, r, v[15:0]));   // Reads r one cycle later
   endtask

   task automatic startTest(input string name);
      testName     = name;
      testErrStart = errCount;
      testInstrs   = 0;
   endtask

   task automatic endTest();
      int errs;
      repeat (4) idle();                            // Last checks land first
      errs = errCount - testErrStart;
      $display("%s: %0d instructions, %0d errors", testName, testInstrs, errs);
      testsRun++;
      if (errs != 0) begin
         testsFailed++;
      end
   endtask

   task automatic runLoads();
      logic [4:0] r;
      startTest("loads");
      for (int i = 0; i < loadIters; i++) begin
         r = 5'(1 + ({$random(seed)} % 31));
         loadConst(r, $random(seed));
      end
      loadConst(5'd0, $random(seed));               // Must be discarded
      issue(encR(aluPkg::functOr, 5'd5, 5'd0, 5'd0, 5'd0));
      endTest();
   endtask

   task automatic runArith();
      startTest("arith");
      loadConst(5'd1, 32'h7FFF_FFFF);
      loadConst(5'd2, 32'h8000_0000);
      loadConst(5'd3, 32'h0000_0001);
      loadConst(5'd4, 32'hFFFF_FFFF);
      issue(encR(aluPkg::functAdd, 5'd10, 5'd1, 5'd3, 5'd0));   // Max positive + 1
      issue(encR(aluPkg::functAdd, 5'd10, 5'd2, 5'd2, 5'd0));   // Min negative doubled
      issue(encR(aluPkg::functAdd, 5'd10, 5'd4, 5'd3, 5'd0));   // Wraps to zero
      issue(encR(aluPkg::functSub, 5'd10, 5'd2, 5'd3, 5'd0));
      issue(encR(aluPkg::functSub, 5'd10, 5'd1, 5'd1, 5'd0));   // Equal operands
      issue(encR(aluPkg::functSub, 5'd10, 5'd3, 5'd4, 5'd0));   // Borrow
      issue(encI(aluPkg::opcAddi, 5'd10, 5'd1, 16'h0001));
      issue(encI(aluPkg::opcAddi, 5'd10, 5'd3, 16'hFFFF));
      for (int i = 0; i < arithIters; i++) begin
         loadConst(5'd7, $random(seed));
         loadConst(5'd8, $random(seed));
         issue(encR(aluPkg::functAdd, 5'd9, 5'd7, 5'd8, 5'd0));
         issue(encR(aluPkg::functSub, 5'd9, 5'd7, 5'd8, 5'd0));
         issue(encI(aluPkg::opcAddi, 5'd9, 5'd7, 16'($random(seed))));
      end
      endTest();
   endtask

   task automatic runMulDiv();
      logic [31:0] v;
      startTest("muldiv");
      loadConst(5'd5, 32'd3);
      for (int i = 0; i < mdIters; i++) begin
         loadConst(5'd1, $random(seed));
         v = $random(seed);
         if (i % 2 == 1) begin
            v = v >> 20;                            // Small factor and divisor
         end
         loadConst(5'd2, v);
         issue(encR(aluPkg::functMul, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functMul, 5'd3, 5'd1, 5'd5, 5'd0));
         issue(encR(aluPkg::functDivu, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functDivu, 5'd3, 5'd1, 5'd5, 5'd0));
         issue(encR(aluPkg::functDivu, 5'd3, 5'd1, 5'd0, 5'd0));   // Zero divisor
      end
      for (int s = 0; s < 32; s++) begin
         issue(encR(aluPkg::functSll, 5'd3, 5'd0, 5'd1, 5'(s)));
         issue(encR(aluPkg::functSrl, 5'd3, 5'd0, 5'd1, 5'(s)));
      end
      endTest();
   endtask

   task automatic runLogic();
      logic [31:0] v1;
      logic [31:0] v2;
      startTest("logic");
      for (int i = 0; i < logicIters; i++) begin
         v1     = $random(seed);
         v2     = $random(seed);
         v2[31] = (i % 2 == 1) ? ~v1[31] : v1[31];  // Mixed signs every other pass
         loadConst(5'd1, v1);
         loadConst(5'd2, v2);
         issue(encR(aluPkg::functAnd, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functOr, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functXor, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functNor, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functSlt, 5'd3, 5'd1, 5'd2, 5'd0));
         issue(encR(aluPkg::functSlt, 5'd3, 5'd2, 5'd1, 5'd0));
      end
      endTest();
   endtask

   // Word k reads the result of word k-d through r10..r12
   task automatic runDeps();
      logic [4:0] r;
      startTest("deps");
      for (int d = 1; d <= 3; d++) begin
         loadConst(5'd1, $random(seed));
         for (int k = 0; k < chainLen; k++) begin
            r = 5'(10 + (k % d));
            case (k % 3)
               0: issue(encR(aluPkg::functAdd, r, r, 5'd1, 5'd0));
               1: issue(encR(aluPkg::functSub, r, 5'd1, r, 5'd0));     // Hazard on rt
               default: issue(encI(aluPkg::opcAddi, r, r, 16'($random(seed))));
            endcase
         end
      end
      endTest();
   endtask

   task automatic runIllegal();
      startTest("illegal");
      loadConst(5'd5, $random(seed));
      for (int i = 0; i < illIters; i++) begin
         issue(illegalWord(2*i, $random(seed)));
         issue(illegalWord(2*i + 1, $random(seed)));
         issue(encR(aluPkg::functOr, 5'd6, 5'd5, 5'd0, 5'd0));      // r5 still intact
      end
      endTest();
   endtask

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Run timed out after %0d cycles in test %s", watchdogCycles, testName);
      $display("tests failed");
      $finish;
   end

   initial begin
      instrValid = 1'b0;
      instr      = '0;
      expIn      = '0;
      for (int i = 0; i < aluPkg::numRegs; i++) begin
         regModel[i] = '0;                          // Matches reset state
      end
      @(posedge rstN);
      @(posedge clk);
      runLoads();
      runArith();
      runMulDiv();
      runLogic();
      runDeps();
      runIllegal();
      $display("%0d tests, %0d with errors, %0d errors in total",
               testsRun, testsFailed, errCount);
      if (errCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
   output logic clk,
   output logic rstN
);

   localparam time halfPeriod = 10ns;              // 20 ns clock
   localparam int  resetCycles = 5;

   initial begin
      clk = 1'b0;
      forever #(halfPeriod) clk = ~clk;
   end

   initial begin
      rstN = 1'b0;                                  // Held low from time zero
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;                                 // Released on an edge
   end

endmodule

// File: hdl/execCore.sv
`timescale 1ns/1ps

module execCore (
   input  logic              clk,
   input  logic              rstN,
   input  logic              instrValid,     // One strobe per instruction
   input  logic [31:0]       instr,
   output aluPkg::aluRes_t   wb,             // Write-back two cycles after issue
   output logic              illegal         // Dropped word in the wb slot
);

   logic [aluPkg::regAddrWidth-1:0] rdAddrA;
   logic [aluPkg::regAddrWidth-1:0] rdAddrB;
   logic [aluPkg::dataWidth-1:0]    rdDataA;
   logic [aluPkg::dataWidth-1:0]    rdDataB;
   aluPkg::aluReq_t                 req;     // Decoder to ALU
   aluPkg::aluRes_t                 fwd;     // ALU bypass to decoder

   // Producer decodes, reads operands and bypasses
   instrDecoder instrDecoder0 (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .instr      (instr),
      .rdAddrA    (rdAddrA),
      .rdAddrB    (rdAddrB),
      .rdDataA    (rdDataA),
      .rdDataB    (rdDataB),
      .fwd        (fwd),
      .req        (req),
      .illegal    (illegal)
   );

   // Register storage written from wb
   regFile regFile0 (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wb      (wb)
   );

   // Consumer computes and registers the result
   alu alu0 (
      .clk  (clk),
      .rstN (rstN),
      .req  (req),
      .fwd  (fwd),
      .wb   (wb)
   );

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
   input  logic              clk,
   input  logic              rstN,
   input  aluPkg::aluReq_t   req,
   output aluPkg::aluRes_t   fwd,           // Same-cycle result for the decoder bypass
   output aluPkg::aluRes_t   wb             // Registered write-back
);

   logic [aluPkg::dataWidth:0]       sum;          // 33 bits with carry on top
   logic [aluPkg::dataWidth:0]       diff;         // Top is no-borrow
   logic [2*aluPkg::dataWidth-1:0]   prod;         // Full unsigned product
   logic [aluPkg::dataWidth-1:0]     quot;
   logic                             divZero;
   logic [aluPkg::dataWidth-1:0]     result;
   logic                             ovf;
   logic                             carry;
   logic                             msbA;
   logic                             msbB;

   assign msbA = req.a[aluPkg::dataWidth-1];
   assign msbB = req.b[aluPkg::dataWidth-1];

   assign sum     = {1'b0, req.a} + {1'b0, req.b};
   assign diff    = {1'b0, req.a} + {1'b0, ~req.b} + 33'd1;   // a + ~b + 1
   assign prod    = 64'(req.a) * 64'(req.b);
   assign divZero = (req.b == '0);
   assign quot    = divZero ? aluPkg::allOnes : (req.a / req.b);

   // Result mux
   always_comb begin
      case (req.op)
         aluPkg::opAdd:  result = sum[aluPkg::dataWidth-1:0];
         aluPkg::opSub:  result = diff[aluPkg::dataWidth-1:0];
         aluPkg::opMul:  result = prod[aluPkg::dataWidth-1:0];   // Low word
         aluPkg::opDivu: result = quot;
         aluPkg::opSll:  result = req.a << req.shamt;
         aluPkg::opSrl:  result = req.a >> req.shamt;            // Logical shift with zero fill
         aluPkg::opAnd:  result = req.a & req.b;
         aluPkg::opOr:   result = req.a | req.b;
         aluPkg::opXor:  result = req.a ^ req.b;
         aluPkg::opNor:  result = ~(req.a | req.b);
         aluPkg::opSlt:  result = {31'b0, $signed(req.a) < $signed(req.b)};
         aluPkg::opLui:  result = req.b;                         // Already shifted
         default:        result = '0;
      endcase
   end

   // Flags from the same cycle's operands
   always_comb begin
      ovf   = 1'b0;
      carry = 1'b0;
      case (req.op)
         aluPkg::opAdd: begin
            ovf   = (msbA == msbB) && (sum[aluPkg::dataWidth-1] != msbA);
            carry = sum[aluPkg::dataWidth];
         end
         aluPkg::opSub: begin
            ovf   = (msbA != msbB) && (diff[aluPkg::dataWidth-1] != msbA);
            carry = diff[aluPkg::dataWidth];                     // 1 when a >= b unsigned
         end
         aluPkg::opMul:  ovf = |prod[2*aluPkg::dataWidth-1:aluPkg::dataWidth];
         aluPkg::opDivu: ovf = divZero;
         default: begin
            ovf   = 1'b0;
            carry = 1'b0;
         end
      endcase
   end

   always_comb begin
      fwd          = '0;
      fwd.valid    = req.valid;
      fwd.dest     = req.dest;
      fwd.writes   = req.writes;
      fwd.value    = result;
      fwd.zero     = (result == '0);
      fwd.overflow = ovf;
      fwd.carryOut = carry;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wb <= '0;
      end else begin
         wb <= fwd;                                // One stage to write-back
      end
   end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic [aluPkg::regAddrWidth-1:0]   rdAddrA,
   input  logic [aluPkg::regAddrWidth-1:0]   rdAddrB,
   output logic [aluPkg::dataWidth-1:0]      rdDataA,
   output logic [aluPkg::dataWidth-1:0]      rdDataB,
   input  aluPkg::aluRes_t                   wb            // Registered ALU result
);

   logic [aluPkg::dataWidth-1:0] regs [1:aluPkg::numRegs-1];   // r0 not stored
   logic                         wrEn;

   assign wrEn = wb.valid && wb.writes && (wb.dest != '0);

   // r0 reads zero; the value being written wins over the array
   function automatic logic [aluPkg::dataWidth-1:0] readPort(
      input logic [aluPkg::regAddrWidth-1:0] addr
   );
      if (addr == '0) begin
         return '0;
      end
      if (wrEn && (wb.dest == addr)) begin
         return wb.value;                          // Write-through
      end
      return regs[addr];
   endfunction

   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 1; i < aluPkg::numRegs; i++) begin
            regs[i] <= '0;                         // All registers start at zero
         end
      end else if (wrEn) begin
         regs[wb.dest] <= wb.value;
      end
   end

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
   input  logic                                 clk,
   input  logic                                 rstN,
   input  logic                                 instrValid,   // One strobe per word
   input  logic [31:0]                          instr,
   output logic [aluPkg::regAddrWidth-1:0]      rdAddrA,      // rs
   output logic [aluPkg::regAddrWidth-1:0]      rdAddrB,      // rt
   input  logic [aluPkg::dataWidth-1:0]         rdDataA,
   input  logic [aluPkg::dataWidth-1:0]         rdDataB,
   input  aluPkg::aluRes_t                      fwd,          // Unregistered ALU result
   output aluPkg::aluReq_t                      req,
   output logic                                 illegal       // Lines up with write-back slot
);

   logic [5:0]                        opcode;
   logic [5:0]                        funct;
   logic [aluPkg::regAddrWidth-1:0]   rs;
   logic [aluPkg::regAddrWidth-1:0]   rt;
   logic [aluPkg::regAddrWidth-1:0]   rd;
   logic [aluPkg::shamtWidth-1:0]     shamt;
   logic [15:0]                       imm;
   logic [aluPkg::dataWidth-1:0]      srcA;          // rs after forwarding
   logic [aluPkg::dataWidth-1:0]      srcB;          // rt after forwarding
   logic                              legal;
   logic                              illegalDet;
   logic                              illegalStage;  // Mirrors the request stage
   aluPkg::aluReq_t                   reqNext;

   // Standard MIPS field split
   assign opcode = instr[31:26];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign shamt  = instr[10:6];
   assign funct  = instr[5:0];
   assign imm    = instr[15:0];

   assign rdAddrA = rs;
   assign rdAddrB = rt;

   // Result of the request now in the ALU beats the register file
   function automatic logic [aluPkg::dataWidth-1:0] pickSrc(
      input logic [aluPkg::regAddrWidth-1:0] addr,
      input logic [aluPkg::dataWidth-1:0]    regVal
   );
      if (fwd.valid && fwd.writes && (fwd.dest == addr)) begin
         return fwd.value;
      end
      return regVal;                                // Write-back hazard handled by regFile
   endfunction

   always_comb begin
      srcA = pickSrc(rs, rdDataA);
      srcB = pickSrc(rt, rdDataB);
   end

   always_comb begin
      reqNext       = '0;
      reqNext.op    = aluPkg::opAdd;
      reqNext.a     = srcA;
      reqNext.b     = srcB;
      reqNext.shamt = shamt;
      reqNext.dest  = rd;                           // R-type default
      legal         = 1'b1;
      case (opcode)
         aluPkg::opcRType: begin
            case (funct)
               aluPkg::functAdd:  reqNext.op = aluPkg::opAdd;
               aluPkg::functSub:  reqNext.op = aluPkg::opSub;
               aluPkg::functMul:  reqNext.op = aluPkg::opMul;
               aluPkg::functDivu: reqNext.op = aluPkg::opDivu;
               aluPkg::functAnd:  reqNext.op = aluPkg::opAnd;
               aluPkg::functOr:   reqNext.op = aluPkg::opOr;
               aluPkg::functXor:  reqNext.op = aluPkg::opXor;
               aluPkg::functNor:  reqNext.op = aluPkg::opNor;
               aluPkg::functSlt:  reqNext.op = aluPkg::opSlt;
               aluPkg::functSll: begin
                  reqNext.op = aluPkg::opSll;
                  reqNext.a  = srcB;                // Shifts act on rt
               end
               aluPkg::functSrl: begin
                  reqNext.op = aluPkg::opSrl;
                  reqNext.a  = srcB;
               end
               default: legal = 1'b0;               // Unknown funct
            endcase
         end
         aluPkg::opcAddi: begin
            reqNext.op   = aluPkg::opAdd;
            reqNext.b    = {{16{imm[15]}}, imm};    // Sign extend
            reqNext.dest = rt;
         end
         aluPkg::opcOri: begin
            reqNext.op   = aluPkg::opOr;
            reqNext.b    = {16'h0000, imm};         // Zero extend
            reqNext.dest = rt;
         end
         aluPkg::opcLui: begin
            reqNext.op   = aluPkg::opLui;
            reqNext.b    = {imm, 16'h0000};
            reqNext.dest = rt;
         end
         default: legal = 1'b0;                     // Unknown opcode
      endcase
      reqNext.writes = (reqNext.dest != '0);        // r0 results dropped
      reqNext.valid  = instrValid && legal;
   end

   assign illegalDet = instrValid && !legal;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         req          <= '0;
         illegalStage <= 1'b0;
         illegal      <= 1'b0;
      end else begin
         req          <= reqNext;
         illegalStage <= illegalDet;
         illegal      <= illegalStage;              // Two cycles like wb
      end
   end

endmodule

// File: hdl/aluPkg.sv
package aluPkg;

   localparam int dataWidth    = 32;                     // Data word width
   localparam int regAddrWidth = 5;                      // Register address width
   localparam int numRegs      = 32;                     // r0..r31
   localparam int shamtWidth   = 5;                      // Shift amount field

   localparam logic [dataWidth-1:0] allOnes = '1;        // Quotient for divide by zero

   // MIPS primary opcodes
   localparam logic [5:0] opcRType = 6'h00;              // R-type group decoded by funct
   localparam logic [5:0] opcAddi  = 6'h08;              // Sign-extended imm
   localparam logic [5:0] opcOri   = 6'h0D;              // Zero-extended imm
   localparam logic [5:0] opcLui   = 6'h0F;              // Upper half load

   // MIPS funct codes for R-type
   localparam logic [5:0] functSll  = 6'h00;
   localparam logic [5:0] functSrl  = 6'h02;
   localparam logic [5:0] functMul  = 6'h19;             // Low word in the multu slot
   localparam logic [5:0] functDivu = 6'h1B;
   localparam logic [5:0] functAdd  = 6'h20;
   localparam logic [5:0] functSub  = 6'h22;
   localparam logic [5:0] functAnd  = 6'h24;
   localparam logic [5:0] functOr   = 6'h25;
   localparam logic [5:0] functXor  = 6'h26;
   localparam logic [5:0] functNor  = 6'h27;
   localparam logic [5:0] functSlt  = 6'h2A;             // Signed compare

   // ALU control codes
   typedef enum logic [3:0] {
      opAdd  = 4'b0000,                                  // a + b
      opSub  = 4'b0001,                                  // a - b
      opMul  = 4'b0010,                                  // Low word, unsigned
      opDivu = 4'b0011,                                  // Unsigned quotient
      opSll  = 4'b0100,                                  // a << shamt
      opSrl  = 4'b0101,                                  // a >> shamt
      opAnd  = 4'b1000,
      opOr   = 4'b1001,
      opXor  = 4'b1010,
      opNor  = 4'b1011,
      opSlt  = 4'b1110,                                  // Signed less-than
      opLui  = 4'b1111                                   // Pass b through
   } aluOp_e;

   // Decoded request from decoder to ALU
   typedef struct packed {
      logic                    valid;                    // Request present
      aluOp_e                  op;
      logic [dataWidth-1:0]    a;                        // Operand A, forwarded
      logic [dataWidth-1:0]    b;                        // Operand B or immediate
      logic [shamtWidth-1:0]   shamt;
      logic [regAddrWidth-1:0] dest;                     // Destination register
      logic                    writes;                   // Low for r0 targets
   } aluReq_t;

   // Result and flags from ALU to register file
   typedef struct packed {
      logic                    valid;
      logic [regAddrWidth-1:0] dest;
      logic                    writes;
      logic [dataWidth-1:0]    value;
      logic                    zero;                     // Result is all zero
      logic                    overflow;                 // Signed ovf, mul high, div by 0
      logic                    carryOut;                 // Add carry, sub no-borrow
   } aluRes_t;

endpackage
